// ==== mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// data path and address width
`define MEM_WORD_SIZE 32

// page number bits above the 4 KiB offset
`define MEM_PAGE_WIDTH 20

// one line holds four words
`define MEM_LINE_SIZE 128
`define MEM_CACHE_LINES 8

`define MEM_TLB_ENTRIES 4

// pending stores waiting on the ROB
`define MEM_SB_DEPTH 4
`define MEM_ROB_ID_WIDTH 4

`endif

// ==== mem_pkg.sv ====
`include "mem_config.svh"

package mem_pkg;

    localparam int OFFSET_W = `MEM_WORD_SIZE - `MEM_PAGE_WIDTH;
    localparam int BYTE_W = $clog2(`MEM_WORD_SIZE / 8);
    localparam int WORD_W = $clog2(`MEM_LINE_SIZE / `MEM_WORD_SIZE);
    localparam int INDEX_W = $clog2(`MEM_CACHE_LINES);
    localparam int TAG_W = `MEM_WORD_SIZE - INDEX_W - WORD_W - BYTE_W;

    // funct3[1:0], funct3[2] selects zero extension
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    typedef struct packed {
        logic [`MEM_PAGE_WIDTH-1:0] page;
        logic [OFFSET_W-1:0]        offset;
    } page_view_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [WORD_W-1:0]  word;     // word within the line
        logic [BYTE_W-1:0]  byte_sel;
    } line_view_t;

    // tlb reads the page view, the cache reads the line view
    typedef union packed {
        page_view_t pg;
        line_view_t ln;
    } vaddr_u;

    typedef struct packed {
        logic                         store;
        logic [2:0]                   funct3;
        vaddr_u                       vaddr;
        logic [`MEM_WORD_SIZE-1:0]    value;   // store data
        logic [`MEM_ROB_ID_WIDTH-1:0] rob_id;
    } access_t;

    typedef struct packed {
        logic                         valid;
        logic                         committed;
        vaddr_u                       paddr;
        logic [`MEM_WORD_SIZE-1:0]    value;
        logic [1:0]                   size;
        logic [`MEM_ROB_ID_WIDTH-1:0] rob_id;
    } sb_entry_t;

    typedef struct packed {
        logic                      req;
        logic [`MEM_WORD_SIZE-1:0] req_addr;
        logic                      write;
        logic [`MEM_WORD_SIZE-1:0] write_addr;
        logic [`MEM_LINE_SIZE-1:0] write_data;
    } line_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`MEM_PAGE_WIDTH-1:0] vpage;
        logic [`MEM_PAGE_WIDTH-1:0] ppage;
    } tlb_fill_t;

endpackage

// ==== dtlb.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module dtlb (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid,
    input  mem_pkg::vaddr_u            vaddr,
    input  mem_pkg::tlb_fill_t         fill,
    output logic [`MEM_PAGE_WIDTH-1:0] phys_page,
    output logic                       tlb_hit,
    output logic                       tlb_miss
);

    localparam int N = `MEM_TLB_ENTRIES;
    localparam int IW = $clog2(N);

    logic [N-1:0]               ent_valid;
    logic [`MEM_PAGE_WIDTH-1:0] vpages [N];
    logic [`MEM_PAGE_WIDTH-1:0] ppages [N];
    logic [N-1:0]               match;
    logic [N-1:0]               fill_match;  // fill page already present
    logic [IW-1:0]              rr_ptr;
    logic [IW-1:0]              fill_slot;

    always_comb begin
        match = '0;
        fill_match = '0;
        phys_page = '0;
        fill_slot = rr_ptr;
        for (int i = 0; i < N; i++) begin
            match[i] = ent_valid[i] && (vpages[i] == vaddr.pg.page);
            fill_match[i] = ent_valid[i] && (vpages[i] == fill.vpage);
            if (match[i])
                phys_page = ppages[i];
            if (fill_match[i])
                fill_slot = IW'(i);  // overwrite in place
        end
    end

    assign tlb_hit = valid && (|match);
    assign tlb_miss = valid && !(|match);

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
            rr_ptr <= '0;
        end else if (fill.valid) begin
            ent_valid[fill_slot] <= 1'b1;
            if (!(|fill_match))
                rr_ptr <= rr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            vpages[fill_slot] <= fill.vpage;
            ppages[fill_slot] <= fill.ppage;
        end
    end

    // refills of a present page must never leave a duplicate behind
    a_one_match: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

// ==== dcache.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module dcache (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_en,
    input  mem_pkg::vaddr_u           paddr,
    input  logic [2:0]                funct3,
    input  mem_pkg::sb_entry_t        sb_head,
    input  logic                      mem_res,
    input  logic [`MEM_WORD_SIZE-1:0] mem_res_addr,
    input  logic [`MEM_LINE_SIZE-1:0] mem_res_data,
    output logic                      load_busy,
    output logic [`MEM_WORD_SIZE-1:0] read_data,
    output logic                      store_done,
    output mem_pkg::line_req_t        mem_out
);

    localparam int W = `MEM_WORD_SIZE;
    localparam int LINES = `MEM_CACHE_LINES;
    localparam int BYTES = W / 8;
    localparam int LOW_W = mem_pkg::WORD_W + mem_pkg::BYTE_W;
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_WB = 2'd1;
    localparam logic [1:0] S_FILL = 2'd2;

    logic [mem_pkg::TAG_W-1:0] tags [LINES];
    logic [`MEM_LINE_SIZE-1:0] lines [LINES];
    logic [LINES-1:0]          valid_bits;
    logic [LINES-1:0]          dirty_bits;

    logic [1:0]      state;
    mem_pkg::vaddr_u miss_addr;  // line being refilled
    mem_pkg::vaddr_u res_addr;

    logic             load_hit;
    logic             drain_req;
    logic             drain_hit;
    logic             start_load;
    logic             start_drain;
    logic [W-1:0]     load_word;
    logic [W-1:0]     shifted;
    logic [W-1:0]     old_word;
    logic [W-1:0]     st_word;
    logic [W-1:0]     merged_word;
    logic [BYTES-1:0] st_mask;

    assign res_addr = mem_res_addr;

    assign load_hit = valid_bits[paddr.ln.index] && (tags[paddr.ln.index] == paddr.ln.tag);
    assign drain_req = sb_head.valid && sb_head.committed;
    assign drain_hit = valid_bits[sb_head.paddr.ln.index]
                       && (tags[sb_head.paddr.ln.index] == sb_head.paddr.ln.tag);

    // loads win, a drain only goes when the load port is quiet
    assign load_busy = load_en && !load_hit;
    assign store_done = (state == S_IDLE) && !load_en && drain_req && drain_hit;
    assign start_load = (state == S_IDLE) && load_busy;
    assign start_drain = (state == S_IDLE) && !load_en && drain_req && !drain_hit;

    assign load_word = lines[paddr.ln.index][paddr.ln.word * W +: W];
    assign shifted = load_word >> (paddr.ln.byte_sel * 8);

    always_comb begin
        case (funct3[1:0])
            mem_pkg::SZ_BYTE: read_data = {{(W - 8){shifted[7] & ~funct3[2]}}, shifted[7:0]};
            mem_pkg::SZ_HALF: read_data = {{(W - 16){shifted[15] & ~funct3[2]}}, shifted[15:0]};
            default:          read_data = shifted;
        endcase
    end

    // byte lane merge of the head store
    assign old_word = lines[sb_head.paddr.ln.index][sb_head.paddr.ln.word * W +: W];
    assign st_word = sb_head.value << (sb_head.paddr.ln.byte_sel * 8);

    always_comb begin
        case (sb_head.size)
            mem_pkg::SZ_BYTE: st_mask = BYTES'(1) << sb_head.paddr.ln.byte_sel;
            mem_pkg::SZ_HALF: st_mask = BYTES'(3) << sb_head.paddr.ln.byte_sel;
            default:          st_mask = '1;
        endcase
        for (int b = 0; b < BYTES; b++)
            merged_word[b*8 +: 8] = st_mask[b] ? st_word[b*8 +: 8] : old_word[b*8 +: 8];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_load || start_drain)
                        state <= S_WB;
                    if (store_done)
                        dirty_bits[sb_head.paddr.ln.index] <= 1'b1;
                end
                S_WB: state <= S_FILL;  // victim and request leave this cycle
                default: begin
                    if (mem_res) begin
                        valid_bits[miss_addr.ln.index] <= 1'b1;
                        dirty_bits[miss_addr.ln.index] <= 1'b0;
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_load)
            miss_addr <= paddr;
        else if (start_drain)
            miss_addr <= sb_head.paddr;
        if (state == S_FILL && mem_res) begin
            lines[miss_addr.ln.index] <= mem_res_data;
            tags[miss_addr.ln.index] <= miss_addr.ln.tag;
        end else if (store_done) begin
            lines[sb_head.paddr.ln.index][sb_head.paddr.ln.word * W +: W] <= merged_word;
        end
    end

    always_comb begin
        mem_out.req = (state == S_WB);
        mem_out.req_addr = {miss_addr.ln.tag, miss_addr.ln.index, {LOW_W{1'b0}}};
        mem_out.write = (state == S_WB) && valid_bits[miss_addr.ln.index]
                        && dirty_bits[miss_addr.ln.index];
        mem_out.write_addr = {tags[miss_addr.ln.index], miss_addr.ln.index, {LOW_W{1'b0}}};
        mem_out.write_data = lines[miss_addr.ln.index];
    end

    // memory must answer only the line we asked for
    a_fill_addr: assert property (@(posedge clk) disable iff (rst)
        mem_res |-> (state == S_FILL) && (res_addr.ln.tag == miss_addr.ln.tag)
                    && (res_addr.ln.index == miss_addr.ln.index));

endmodule

// ==== store_buffer.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module store_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  mem_pkg::access_t             access,
    input  mem_pkg::vaddr_u              phys_addr,
    input  logic                         permission,
    input  logic [`MEM_ROB_ID_WIDTH-1:0] permission_rob_id,
    input  logic                         store_done,
    output mem_pkg::sb_entry_t           sb_head,
    output logic                         sb_full,
    output logic                         sb_match
);

    localparam int DEPTH = `MEM_SB_DEPTH;
    localparam int PW = $clog2(DEPTH);
    localparam int HI = `MEM_WORD_SIZE - 1;
    localparam int LO = mem_pkg::BYTE_W;

    mem_pkg::sb_entry_t slots [DEPTH];
    logic [PW-1:0]      head;
    logic [PW-1:0]      tail;
    logic [PW:0]        count;

    // dcache only drains it once committed
    assign sb_head = slots[head];
    assign sb_full = (count == (PW + 1)'(DEPTH));

    // word granular, any valid slot blocks the load
    always_comb begin
        sb_match = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (slots[i].valid && (slots[i].paddr[HI:LO] == phys_addr[HI:LO]))
                sb_match = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                slots[i].valid <= 1'b0;
                slots[i].committed <= 1'b0;
            end
        end else begin
            // commit mark, rob ids are unique among live slots
            if (permission) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (slots[i].valid && (slots[i].rob_id == permission_rob_id))
                        slots[i].committed <= 1'b1;
                end
            end
            if (push) begin
                slots[tail].valid <= 1'b1;
                slots[tail].committed <= 1'b0;
                slots[tail].paddr <= phys_addr;
                slots[tail].value <= access.value;
                slots[tail].size <= access.funct3[1:0];
                slots[tail].rob_id <= access.rob_id;
                tail <= tail + 1'b1;
            end
            if (store_done) begin
                slots[head].valid <= 1'b0;  // retire
                head <= head + 1'b1;
            end
            count <= count + (PW + 1)'(push) - (PW + 1)'(store_done);
        end
    end

    // the stage controller holds stores back while full
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !sb_full);

endmodule

// ==== stage_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module stage_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         valid,
    input  mem_pkg::access_t             access,
    input  logic                         tlb_hit,
    input  logic                         tlb_miss,
    input  logic                         load_busy,
    input  logic                         sb_full,
    input  logic                         sb_match,
    output logic                         stall_out,
    output logic                         valid_out,
    output logic                         exception,
    output logic                         cache_load_en,
    output logic                         sb_push,
    output logic [`MEM_WORD_SIZE-1:0]    v_addr_exception
);

    logic                         exc_seen;  // already reported for this rob id
    logic [`MEM_ROB_ID_WIDTH-1:0] exc_id;
    logic                         is_store;

    assign is_store = access.store;

    // tlb miss takes priority, no stall on it
    assign exception = valid && tlb_miss && !(exc_seen && (access.rob_id == exc_id));
    assign v_addr_exception = access.vaddr;

    assign cache_load_en = valid && tlb_hit && !is_store && !sb_match;
    assign stall_out = valid && tlb_hit && (is_store ? sb_full : (sb_match || load_busy));
    assign valid_out = valid && tlb_hit && !stall_out;
    assign sb_push = valid_out && is_store;

    always_ff @(posedge clk) begin
        if (rst)
            exc_seen <= 1'b0;
        else if (exception)
            exc_seen <= 1'b1;
        else if (!valid || (access.rob_id != exc_id))
            exc_seen <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (exception)
            exc_id <= access.rob_id;
    end

    // tlb hit and miss come from the dtlb and must stay exclusive
    a_excl_out: assert property (@(posedge clk) disable iff (rst) !(valid_out && exception));

endmodule

// ==== cache_stage.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         valid,
    input  mem_pkg::access_t             access,
    output logic                         stall_out,  // back to the previous stage
    output logic                         valid_out,
    output logic [`MEM_WORD_SIZE-1:0]    read_data,
    output mem_pkg::line_req_t           mem_out,
    input  logic                         mem_res,
    input  logic [`MEM_WORD_SIZE-1:0]    mem_res_addr,
    input  logic [`MEM_LINE_SIZE-1:0]    mem_res_data,
    input  logic                         rob_store_permission,
    input  logic [`MEM_ROB_ID_WIDTH-1:0] rob_sb_permission_rob_id,
    input  mem_pkg::tlb_fill_t           tlb_fill,
    output logic                         exception,
    output logic [`MEM_WORD_SIZE-1:0]    v_addr_exception
);

    logic [`MEM_PAGE_WIDTH-1:0] phys_page;
    logic                       tlb_hit;
    logic                       tlb_miss;
    logic                       load_busy;
    logic                       sb_full;
    logic                       sb_match;
    logic                       cache_load_en;
    logic                       sb_push;
    logic                       store_done;
    mem_pkg::vaddr_u            paddr;
    mem_pkg::sb_entry_t         sb_head;

    // translated page, offset passes straight through
    assign paddr = {phys_page, access.vaddr.pg.offset};

    stage_ctrl u_ctrl (
        .clk(clk), .rst(rst), .valid(valid), .access(access),
        .tlb_hit(tlb_hit), .tlb_miss(tlb_miss), .load_busy(load_busy),
        .sb_full(sb_full), .sb_match(sb_match), .stall_out(stall_out),
        .valid_out(valid_out), .exception(exception), .cache_load_en(cache_load_en),
        .sb_push(sb_push), .v_addr_exception(v_addr_exception)
    );

    dtlb u_dtlb (
        .clk(clk), .rst(rst), .valid(valid), .vaddr(access.vaddr), .fill(tlb_fill),
        .phys_page(phys_page), .tlb_hit(tlb_hit), .tlb_miss(tlb_miss)
    );

    dcache u_dcache (
        .clk(clk), .rst(rst), .load_en(cache_load_en), .paddr(paddr),
        .funct3(access.funct3), .sb_head(sb_head), .mem_res(mem_res),
        .mem_res_addr(mem_res_addr), .mem_res_data(mem_res_data), .load_busy(load_busy),
        .read_data(read_data), .store_done(store_done), .mem_out(mem_out)
    );

    store_buffer u_sb (
        .clk(clk), .rst(rst), .push(sb_push), .access(access), .phys_addr(paddr),
        .permission(rob_store_permission), .permission_rob_id(rob_sb_permission_rob_id),
        .store_done(store_done), .sb_head(sb_head), .sb_full(sb_full), .sb_match(sb_match)
    );

endmodule

// ==== tb_cache_stage.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_cache_stage;

    localparam logic [2:0] OP_FILL = 3'd0;
    localparam logic [2:0] OP_LOAD = 3'd1;
    localparam logic [2:0] OP_STORE = 3'd2;
    localparam logic [2:0] OP_COMMIT = 3'd3;
    localparam logic [2:0] OP_FLUSH = 3'd4;
    localparam logic [2:0] OP_BAD = 3'd7;
    localparam logic [7:0] NO_HOLD = 8'hff;
    localparam int WORDS = `MEM_LINE_SIZE / `MEM_WORD_SIZE;
    localparam int QUIET_CYCLES = 2 * `MEM_SB_DEPTH;  // longer than any run of hit drains

    typedef struct packed {
        logic [2:0]  op;
        logic [2:0]  f3;
        logic [31:0] vaddr;     // virtual page for a fill
        logic [31:0] value;     // physical page for a fill
        logic [7:0]  rob;
        logic [7:0]  hold;      // rob id granted while the access stalls
        logic        exc;
        logic [31:0] expected;
    } case_t;

    logic                         clk;
    logic                         rst;
    logic                         valid;
    mem_pkg::access_t             access;
    logic                         stall_out;
    logic                         valid_out;
    logic                         exception;
    logic [`MEM_WORD_SIZE-1:0]    read_data;
    logic [`MEM_WORD_SIZE-1:0]    v_addr_exception;
    mem_pkg::line_req_t           mem_out;
    logic                         mem_res;
    logic [`MEM_WORD_SIZE-1:0]    mem_res_addr;
    logic [`MEM_LINE_SIZE-1:0]    mem_res_data;
    logic                         rob_store_permission;
    logic [`MEM_ROB_ID_WIDTH-1:0] rob_sb_permission_rob_id;
    mem_pkg::tlb_fill_t           tlb_fill;

    case_t       cases [$];
    int          n_cases = 0;
    logic [31:0] mem_words [logic [31:0]];  // only written-back words live here
    logic [31:0] lfsr = 32'h42a76087;
    logic        pending = 1'b0;            // a line request waits for its answer

    cache_stage i_dut (
        .clk(clk), .rst(rst), .valid(valid), .access(access),
        .stall_out(stall_out), .valid_out(valid_out), .read_data(read_data),
        .mem_out(mem_out), .mem_res(mem_res), .mem_res_addr(mem_res_addr),
        .mem_res_data(mem_res_data), .rob_store_permission(rob_store_permission),
        .rob_sb_permission_rob_id(rob_sb_permission_rob_id), .tlb_fill(tlb_fill),
        .exception(exception), .v_addr_exception(v_addr_exception)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // untouched memory reads back as the inverted byte address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return mem_words.exists(addr) ? mem_words[addr] : ~addr;
    endfunction

    function automatic logic [2:0] op_code(input string s);
        if (s == "fill") return OP_FILL;
        if (s == "load") return OP_LOAD;
        if (s == "store") return OP_STORE;
        if (s == "commit") return OP_COMMIT;
        if (s == "flush-wait") return OP_FLUSH;
        return OP_BAD;
    endfunction

    task automatic abort_run(input string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            abort_run("run stopped at the first wrong value");
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        string       op_s;
        logic [31:0] f [7];
        case_t       c;
        fd = $fopen("cache_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open cache_cases.txt for reading");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h", op_s,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                c = '{op: op_code(op_s), f3: f[0][2:0], vaddr: f[1], value: f[2],
                      rob: f[3][7:0], hold: f[4][7:0], exc: f[5][0], expected: f[6]};
                if (n != 8 || c.op == OP_BAD)
                    abort_run({"the case file has a line that cannot be read: ", line});
                else
                    cases.push_back(c);
            end
            $fclose(fd);
            n_cases = cases.size();
        end
    endtask

    // idle until the memory port stays quiet long enough for all drains
    task automatic wait_drained();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            #1;
            if (mem_out.req || mem_out.write || pending)
                quiet = 0;
            else
                quiet++;
        end
    endtask

    task automatic issue(input case_t c);
        int   waited;
        logic holding;
        waited = 0;
        holding = (c.hold != NO_HOLD);
        valid = 1'b1;
        access.store = (c.op == OP_STORE);
        access.funct3 = c.f3;
        access.vaddr = c.vaddr;
        access.value = c.value;
        access.rob_id = c.rob[`MEM_ROB_ID_WIDTH-1:0];
        #1;
        if (c.exc) begin
            check(32'(exception), 32'd1, "exception flag");
            check(32'(valid_out), 32'd0, "valid_out with exception");
            check(32'(stall_out), 32'd0, "stall_out with exception");
            check(v_addr_exception, c.expected, "exception address");
            @(posedge clk);
            #1;
            check(32'(exception), 32'd0, "exception repeated for a held access");  // once only
        end else begin
            if (holding)
                check(32'(stall_out), 32'd1, "stall_out before the commit");
            while (!valid_out) begin
                check(32'(exception), 32'd0, "exception on a mapped page");
                @(negedge clk);
                waited++;
                rob_store_permission = holding && (waited == 4);  // grant mid-stall
                rob_sb_permission_rob_id = c.hold[`MEM_ROB_ID_WIDTH-1:0];
                #1;
            end
            if (holding)
                check(32'(waited > 4), 32'd1, "access released before its commit");
            if (c.op == OP_LOAD)
                check(read_data, c.expected, "load data");
        end
    endtask

    task automatic run_case(input case_t c);
        @(negedge clk);
        case (c.op)
            OP_FILL: tlb_fill = {1'b1, c.vaddr[`MEM_PAGE_WIDTH-1:0],
                                 c.value[`MEM_PAGE_WIDTH-1:0]};
            OP_COMMIT: begin
                rob_store_permission = 1'b1;
                rob_sb_permission_rob_id = c.rob[`MEM_ROB_ID_WIDTH-1:0];
            end
            OP_FLUSH: wait_drained();
            default: issue(c);
        endcase
        @(negedge clk);
        valid = 1'b0;
        tlb_fill.valid = 1'b0;
        rob_store_permission = 1'b0;
    endtask

    // line memory that answers each request after 1 to 8 cycles
    initial begin
        int          countdown;
        logic [31:0] pend_addr;
        mem_res = 1'b0;
        mem_res_addr = '0;
        mem_res_data = '0;
        countdown = 0;
        pend_addr = '0;
        forever begin
            @(negedge clk);
            mem_res = 1'b0;
            if (mem_out.write) begin
                for (int i = 0; i < WORDS; i++)
                    mem_words[mem_out.write_addr + 32'(4 * i)] = mem_out.write_data[i*32 +: 32];
            end
            if (pending) begin
                countdown--;
                if (countdown == 0) begin
                    mem_res = 1'b1;
                    mem_res_addr = pend_addr;
                    for (int i = 0; i < WORDS; i++)
                        mem_res_data[i*32 +: 32] = word_at(pend_addr + 32'(4 * i));
                    pending = 1'b0;
                end
            end
            if (mem_out.req) begin
                pending = 1'b1;
                pend_addr = mem_out.req_addr;
                countdown = 1;
                for (int b = 0; b < 3; b++) begin
                    countdown += int'(lfsr[0]) << b;
                    lfsr = lfsr_next(lfsr);
                end
            end
        end
    end

    initial begin
        wait (n_cases != 0);
        repeat (n_cases * 200 + 10) @(posedge clk);
        abort_run("watchdog timeout, the cases did not finish in time");
    end

    initial begin
        valid = 1'b0;
        access = '0;
        rob_store_permission = 1'b0;
        rob_sb_permission_rob_id = '0;
        tlb_fill = '0;
        rst = 1'b1;
        read_cases();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (cases[i])
            run_case(cases[i]);
        repeat (2) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

// ==== cache_cases.txt ====
# op f3 vaddr value rob hold exc expected, all numbers in hex
# fill puts the virtual page in vaddr and the physical page in value, hold ff means none
fill       0 00010    00080    0 ff 0 00000000
fill       0 00020    000c1    0 ff 0 00000000
# five load kinds on the inverted address pattern
load       2 00010104 00000000 0 ff 0 fff7fefb
load       0 00010105 00000000 0 ff 0 fffffffe
load       4 00010106 00000000 0 ff 0 000000f7
load       1 00010104 00000000 0 ff 0 fffffefb
load       5 00010106 00000000 0 ff 0 0000fff7
load       0 00010184 00000000 0 ff 0 0000007b
# unmapped page reports the faulting address
load       2 00030010 00000000 1 ff 1 00030010
# byte, half and word stores merged after commit
store      0 00020021 123456a5 1 ff 0 00000000
commit     0 00000000 00000000 1 ff 0 00000000
load       2 00020020 00000000 0 ff 0 fff3a5df
store      1 00020032 beef7a5c 2 ff 0 00000000
commit     0 00000000 00000000 2 ff 0 00000000
load       1 00020032 00000000 0 ff 0 00007a5c
load       4 00020033 00000000 0 ff 0 0000007a
store      2 00020040 cafef00d 3 ff 0 00000000
commit     0 00000000 00000000 3 ff 0 00000000
load       2 00020040 00000000 0 ff 0 cafef00d
# load held behind rob 4 until it commits
store      2 00020050 13579bdf 4 ff 0 00000000
load       2 00020050 00000000 5 04 0 13579bdf
# dirty line at index 0 evicted by another tag and reloaded
store      2 00010108 0badf00d 6 ff 0 00000000
commit     0 00000000 00000000 6 ff 0 00000000
flush-wait 0 00000000 00000000 0 ff 0 00000000
load       2 00010180 00000000 0 ff 0 fff7fe7f
load       2 00010108 00000000 0 ff 0 0badf00d
load       2 0001010c 00000000 0 ff 0 fff7fef3
# fifth store waits for a free slot
store      2 00020060 11111111 7 ff 0 00000000
store      2 00020064 22222222 8 ff 0 00000000
store      2 00020068 33333333 9 ff 0 00000000
store      2 0002006c 44444444 a ff 0 00000000
store      2 00020070 55555555 b 07 0 00000000
load       2 00020060 00000000 0 ff 0 11111111
commit     0 00000000 00000000 8 ff 0 00000000
load       2 00020064 00000000 0 ff 0 22222222

// ==== compile.f ====
+incdir+.
mem_pkg.sv
dtlb.sv
dcache.sv
store_buffer.sv
stage_ctrl.sv
cache_stage.sv
tb_cache_stage.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cache_stage
FILELIST  = compile.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST))) mem_config.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM) cache_cases.txt
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
